//--- design/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// data and address widths on the serial bus
`define DATA_WIDTH 8
`define ADDR_WIDTH 15

// top address bits pick the slave
`define SLAVE_ID_WIDTH 3

// low address bits index a slave's byte memory, 16 bytes each
`define MEM_ADDR_WIDTH 4

// bus population
`define NUM_MASTERS 3
`define NUM_SLAVES 3

// cycles a master waits for an ack before giving up
`define TIMEOUT_CYCLES 16

`endif

//--- design/bus_pkg.sv
`include "bus_settings.svh"

package bus_pkg;

    // serial op bit, write is sent as 1
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_e;

    // master FSM
    typedef enum logic [2:0] {
        ms_idle,
        ms_request,
        ms_send_op,
        ms_send_addr,
        ms_send_data,
        ms_wait_ack,
        ms_recv_data,
        ms_finish
    } master_state_e;

    // slave FSM
    typedef enum logic [2:0] {
        ss_idle,
        ss_recv_addr,
        ss_recv_data,
        ss_write_mem,
        ss_send_data,
        ss_skip
    } slave_state_e;

    // op goes out first, so it sits at the MSB end
    typedef struct packed {
        bus_op_e                op;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
    } master_cmd_t;

    typedef struct packed {
        logic util;
        logic sbit;
    } bus_fwd_t;

    typedef struct packed {
        logic ack;
        logic sbit;
    } bus_ret_t;

    typedef logic [$clog2(`NUM_MASTERS)-1:0] master_id_t;

endpackage

//--- design/bus_controller.sv
`timescale 1ns/10ps
`include "bus_settings.svh"

module bus_controller import bus_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`NUM_MASTERS-1:0] req,
    output logic [`NUM_MASTERS-1:0] grant,
    output master_id_t              current_master
);

    master_id_t              last_q;
    master_id_t              next_id;
    logic [`NUM_MASTERS-1:0] next_grant;

    // first requester after the last owner wins
    always_comb begin
        int cand;
        next_grant = '0;
        next_id    = last_q;
        cand       = 0;
        for (int i = 1; i <= `NUM_MASTERS; i++) begin
            cand = (int'(last_q) + i) % `NUM_MASTERS;
            if (req[cand] && next_grant == '0) begin
                next_grant[cand] = 1'b1;
                next_id          = master_id_t'(cand);
            end
        end
    end

    // owner keeps the bus as long as its req is up
    always_ff @(posedge clk) begin
        if (rst) begin
            grant  <= '0;
            last_q <= '0;
        end else if ((req & grant) == '0) begin
            grant <= next_grant;
            if (next_grant != '0) begin
                last_q <= next_id;
            end
        end
    end

    assign current_master = last_q;

    grant_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(grant)
    ) else $error("grant is not one-hot");

    // a master mid-transfer must not lose the bus
    grant_held: assert property (
        @(posedge clk) disable iff (rst) |(grant & req) |=> $stable(grant)
    ) else $error("grant changed while owner still requests");

endmodule

//--- design/bus_master.sv
`timescale 1ns/10ps
`include "bus_settings.svh"

module bus_master import bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  master_cmd_t            cmd,
    output logic                   busy,
    output logic                   done,
    output logic                   err,
    output logic [`DATA_WIDTH-1:0] rdata,
    output logic                   req,
    input  logic                   grant,
    output bus_fwd_t               fwd,
    input  bus_ret_t               ret
);

    localparam int CNT_W = $clog2(`ADDR_WIDTH);
    localparam int TMO_W = $clog2(`TIMEOUT_CYCLES);
    localparam int SH_W  = $bits(master_cmd_t);

    localparam logic [CNT_W-1:0] LAST_ADDR = CNT_W'(`ADDR_WIDTH - 1);
    localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(`DATA_WIDTH - 1);
    localparam logic [TMO_W-1:0] LAST_TMO  = TMO_W'(`TIMEOUT_CYCLES - 1);

    master_state_e    state;
    bus_op_e          op_q;
    logic [SH_W-1:0]  sh_q;
    logic [CNT_W-1:0] cnt;
    logic [TMO_W-1:0] tmo;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ms_idle;
            err   <= 1'b0;
            cnt   <= '0;
            tmo   <= '0;
        end else begin
            case (state)
                ms_idle: begin
                    // new commands only land here, busy is low
                    if (cmd_valid) begin
                        op_q  <= cmd.op;
                        sh_q  <= cmd;
                        err   <= 1'b0;
                        state <= ms_request;
                    end
                end
                ms_request: begin
                    if (grant) begin
                        state <= ms_send_op;
                    end
                end
                ms_send_op: begin
                    sh_q  <= {sh_q[SH_W-2:0], 1'b0};
                    cnt   <= '0;
                    state <= ms_send_addr;
                end
                ms_send_addr: begin
                    sh_q <= {sh_q[SH_W-2:0], 1'b0};
                    cnt  <= cnt + 1'b1;
                    if (cnt == LAST_ADDR) begin
                        cnt   <= '0;
                        tmo   <= '0;
                        state <= (op_q == op_write) ? ms_send_data : ms_wait_ack;
                    end
                end
                ms_send_data: begin
                    sh_q <= {sh_q[SH_W-2:0], 1'b0};
                    cnt  <= cnt + 1'b1;
                    if (cnt == LAST_DATA) begin
                        cnt   <= '0;
                        state <= ms_wait_ack;
                    end
                end
                ms_wait_ack: begin
                    if (ret.ack) begin
                        // on a read the first data bit rides with ack
                        if (op_q == op_read) begin
                            rdata <= {rdata[`DATA_WIDTH-2:0], ret.sbit};
                            cnt   <= CNT_W'(1);
                            state <= ms_recv_data;
                        end else begin
                            state <= ms_finish;
                        end
                    end else if (tmo == LAST_TMO) begin
                        err   <= 1'b1;
                        state <= ms_finish;
                    end else begin
                        tmo <= tmo + 1'b1;
                    end
                end
                ms_recv_data: begin
                    rdata <= {rdata[`DATA_WIDTH-2:0], ret.sbit};
                    cnt   <= cnt + 1'b1;
                    if (cnt == LAST_DATA) begin
                        state <= ms_finish;
                    end
                end
                ms_finish: begin
                    state <= ms_idle;
                end
                default: begin
                    state <= ms_idle;
                end
            endcase
        end
    end

    assign busy = (state != ms_idle);
    assign done = (state == ms_finish);

    // req drops in finish so the controller can move on
    assign req = !(state inside {ms_idle, ms_finish});

    always_comb begin
        fwd.util = !(state inside {ms_idle, ms_request});
        fwd.sbit = 1'b0;
        if (state inside {ms_send_op, ms_send_addr, ms_send_data}) begin
            fwd.sbit = sh_q[SH_W-1];
        end
    end

    util_needs_grant: assert property (
        @(posedge clk) disable iff (rst) fwd.util |-> grant
    ) else $error("master drives util without grant");

endmodule

//--- design/bus_slave.sv
`timescale 1ns/10ps
`include "bus_settings.svh"

module bus_slave import bus_pkg::*; #(
    parameter int unsigned SELF_ID = 0
) (
    input  logic     clk,
    input  logic     rst,
    input  bus_fwd_t fwd,
    output bus_ret_t ret
);

    localparam int CNT_W = $clog2(`ADDR_WIDTH);
    localparam int DEPTH = 1 << `MEM_ADDR_WIDTH;

    localparam logic [CNT_W-1:0] LAST_ADDR = CNT_W'(`ADDR_WIDTH - 1);
    localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(`DATA_WIDTH - 1);

    localparam logic [`SLAVE_ID_WIDTH-1:0] MY_ID = SELF_ID[`SLAVE_ID_WIDTH-1:0];

    slave_state_e                state;
    logic                        util_q;
    bus_op_e                     op_q;
    logic [`ADDR_WIDTH-2:0]      addr_q;
    logic [`ADDR_WIDTH-1:0]      addr_next;
    logic [`MEM_ADDR_WIDTH-1:0]  idx_q;
    logic [`DATA_WIDTH-1:0]      data_q;
    logic [CNT_W-1:0]            cnt;
    logic [`DATA_WIDTH-1:0]      mem [DEPTH];

    // address including the bit on the wire this cycle
    assign addr_next = {addr_q, fwd.sbit};

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ss_idle;
            util_q <= 1'b0;
            cnt    <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            util_q <= fwd.util;
            case (state)
                ss_idle: begin
                    // op bit is on the wire in the first util cycle
                    if (fwd.util && !util_q) begin
                        op_q  <= bus_op_e'(fwd.sbit);
                        cnt   <= '0;
                        state <= ss_recv_addr;
                    end
                end
                ss_recv_addr: begin
                    addr_q <= addr_next[`ADDR_WIDTH-2:0];
                    cnt    <= cnt + 1'b1;
                    if (cnt == LAST_ADDR) begin
                        cnt   <= '0;
                        idx_q <= addr_next[`MEM_ADDR_WIDTH-1:0];
                        if (addr_next[`ADDR_WIDTH-1 -: `SLAVE_ID_WIDTH] != MY_ID) begin
                            state <= ss_skip;
                        end else if (op_q == op_write) begin
                            state <= ss_recv_data;
                        end else begin
                            data_q <= mem[addr_next[`MEM_ADDR_WIDTH-1:0]];
                            state  <= ss_send_data;
                        end
                    end
                end
                ss_recv_data: begin
                    data_q <= {data_q[`DATA_WIDTH-2:0], fwd.sbit};
                    cnt    <= cnt + 1'b1;
                    if (cnt == LAST_DATA) begin
                        state <= ss_write_mem;
                    end
                end
                ss_write_mem: begin
                    mem[idx_q] <= data_q;
                    state      <= ss_idle;
                end
                ss_send_data: begin
                    data_q <= {data_q[`DATA_WIDTH-2:0], 1'b0};
                    cnt    <= cnt + 1'b1;
                    if (cnt == LAST_DATA) begin
                        state <= ss_idle;
                    end
                end
                ss_skip: begin
                    // someone else's transfer, sit it out
                    if (!fwd.util) begin
                        state <= ss_idle;
                    end
                end
                default: begin
                    state <= ss_idle;
                end
            endcase
        end
    end

    always_comb begin
        ret.ack  = (state == ss_write_mem) || (state == ss_send_data);
        ret.sbit = (state == ss_send_data) ? data_q[`DATA_WIDTH-1] : 1'b0;
    end

    ack_inside_util: assert property (
        @(posedge clk) disable iff (rst) ret.ack |-> fwd.util
    ) else $error("slave acked outside a bus transfer");

endmodule

//--- design/bus_top.sv
`timescale 1ns/10ps
`include "bus_settings.svh"

module bus_top import bus_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [`NUM_MASTERS-1:0]                   cmd_valid,
    input  master_cmd_t [`NUM_MASTERS-1:0]            cmd,
    output logic [`NUM_MASTERS-1:0]                   busy,
    output logic [`NUM_MASTERS-1:0]                   done,
    output logic [`NUM_MASTERS-1:0]                   err,
    output logic [`NUM_MASTERS-1:0][`DATA_WIDTH-1:0]  rdata,
    output logic [`NUM_MASTERS-1:0]                   req,
    output logic [`NUM_MASTERS-1:0]                   grant,
    output master_id_t                                current_master,
    output logic                                      bus_util
);

    bus_fwd_t [`NUM_MASTERS-1:0] m_fwd;
    bus_fwd_t                    fwd_bus;
    bus_ret_t [`NUM_SLAVES-1:0]  s_ret;
    bus_ret_t                    ret_bus;

    bus_controller u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .grant          (grant),
        .current_master (current_master)
    );

    for (genvar m = 0; m < `NUM_MASTERS; m++) begin : g_master
        bus_master u_master (
            .clk       (clk),
            .rst       (rst),
            .cmd_valid (cmd_valid[m]),
            .cmd       (cmd[m]),
            .busy      (busy[m]),
            .done      (done[m]),
            .err       (err[m]),
            .rdata     (rdata[m]),
            .req       (req[m]),
            .grant     (grant[m]),
            .fwd       (m_fwd[m]),
            .ret       (ret_bus)
        );
    end

    for (genvar s = 0; s < `NUM_SLAVES; s++) begin : g_slave
        bus_slave #(
            .SELF_ID (s)
        ) u_slave (
            .clk (clk),
            .rst (rst),
            .fwd (fwd_bus),
            .ret (s_ret[s])
        );
    end

    // forward path follows grant, idle bus when nobody owns it
    always_comb begin
        fwd_bus = '0;
        for (int m = 0; m < `NUM_MASTERS; m++) begin
            if (grant[m]) begin
                fwd_bus = m_fwd[m];
            end
        end
    end

    // unaddressed slaves drive zero, so OR is enough
    always_comb begin
        ret_bus = '0;
        for (int s = 0; s < `NUM_SLAVES; s++) begin
            ret_bus = bus_ret_t'(ret_bus | s_ret[s]);
        end
    end

    assign bus_util = fwd_bus.util;

endmodule

//--- dv/bus_tb.sv
`timescale 1ns/10ps
`include "bus_settings.svh"

module bus_tb import bus_pkg::*; ();

    localparam int MAX_CYCLES = 4000;
    localparam int DONE_WAIT  = 200;

    logic                                     clk;
    logic                                     rst;
    logic [`NUM_MASTERS-1:0]                  cmd_valid;
    master_cmd_t [`NUM_MASTERS-1:0]           cmd;
    logic [`NUM_MASTERS-1:0]                  busy;
    logic [`NUM_MASTERS-1:0]                  done;
    logic [`NUM_MASTERS-1:0]                  err;
    logic [`NUM_MASTERS-1:0][`DATA_WIDTH-1:0] rdata;
    logic [`NUM_MASTERS-1:0]                  req;
    logic [`NUM_MASTERS-1:0]                  grant;
    master_id_t                               current_master;
    logic                                     bus_util;

    // expected contents of the present slaves
    logic [`DATA_WIDTH-1:0] ref_mem [`NUM_SLAVES][1 << `MEM_ADDR_WIDTH];

    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     test_err_start;
    int     cycles;
    integer seed;

    bus_top uut (
        .clk            (clk),
        .rst            (rst),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .busy           (busy),
        .done           (done),
        .err            (err),
        .rdata          (rdata),
        .req            (req),
        .grant          (grant),
        .current_master (current_master),
        .bus_util       (bus_util)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // hard stop for a hung run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped at the cycle limit of %0d", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // grant stays one-hot and current_master follows it
    always @(negedge clk) begin
        if (!rst) begin
            if (!$onehot0(grant)) begin
                $display("grant is not one-hot at time %0t: %b", $time, grant);
                errors = errors + 1;
            end else if (grant != '0) begin
                for (int i = 0; i < `NUM_MASTERS; i++) begin
                    if (grant[i]) begin
                        compare("current_master", 32'(current_master), 32'(i));
                    end
                end
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    function automatic logic [`ADDR_WIDTH-1:0] make_addr(input logic [2:0] id,
                                                         input logic [7:0] mid,
                                                         input logic [3:0] idx);
        return {id, mid, idx};
    endfunction

    task automatic start_test(input string name);
        test_err_start = errors;
        tests_run      = tests_run + 1;
        $display("running %s", name);
    endtask

    task automatic end_test(input string name);
        if (errors == test_err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: FAILED with %0d errors", name, errors - test_err_start);
        end
    endtask

    // one command on one master, returns the reply seen with done
    task automatic run_cmd(input int m, input bus_op_e op, input logic [`ADDR_WIDTH-1:0] addr,
                           input logic [`DATA_WIDTH-1:0] wdata,
                           output logic [`DATA_WIDTH-1:0] rd, output logic er);
        int waited;
        while (busy[m]) @(negedge clk);
        cmd[m].op      = op;
        cmd[m].addr    = addr;
        cmd[m].wdata   = wdata;
        cmd_valid[m]   = 1'b1;
        @(negedge clk);
        cmd_valid[m]   = 1'b0;
        waited = 0;
        while (!done[m] && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done[m]) begin
            $display("no done from master %0d for address %h", m, addr);
            errors = errors + 1;
        end
        rd = rdata[m];
        er = err[m];
    endtask

    task automatic write_byte(input int m, input logic [`ADDR_WIDTH-1:0] addr,
                              input logic [`DATA_WIDTH-1:0] data);
        logic [`DATA_WIDTH-1:0] rd;
        logic                   er;
        logic                   absent;
        absent = (addr[14:12] >= `NUM_SLAVES);
        run_cmd(m, op_write, addr, data, rd, er);
        compare($sformatf("err[%0d]", m), 32'(er), 32'(absent));
        if (!absent) begin
            ref_mem[addr[14:12]][addr[3:0]] = data;
        end
    endtask

    task automatic read_byte(input int m, input logic [`ADDR_WIDTH-1:0] addr);
        logic [`DATA_WIDTH-1:0] rd;
        logic                   er;
        logic                   absent;
        absent = (addr[14:12] >= `NUM_SLAVES);
        run_cmd(m, op_read, addr, '0, rd, er);
        compare($sformatf("err[%0d]", m), 32'(er), 32'(absent));
        if (!absent) begin
            compare($sformatf("rdata[%0d]", m), 32'(rd), 32'(ref_mem[addr[14:12]][addr[3:0]]));
        end
    endtask

    task automatic check_reset_state();
        start_test("reset_state");
        compare("busy", 32'(busy), 32'(0));
        compare("done", 32'(done), 32'(0));
        compare("err", 32'(err), 32'(0));
        compare("req", 32'(req), 32'(0));
        compare("grant", 32'(grant), 32'(0));
        compare("bus_util", 32'(bus_util), 32'(0));
        compare("current_master", 32'(current_master), 32'(0));
        end_test("reset_state");
    endtask

    task automatic write_read_all();
        start_test("write_read_all");
        for (int m = 0; m < `NUM_MASTERS; m++) begin
            for (int s = 0; s < `NUM_SLAVES; s++) begin
                write_byte(m, make_addr(3'(s), 8'h00, 4'(m * 3 + s)), 8'(8'h40 + m * 16 + s));
            end
        end
        for (int m = 0; m < `NUM_MASTERS; m++) begin
            for (int s = 0; s < `NUM_SLAVES; s++) begin
                read_byte(m, make_addr(3'(s), 8'h00, 4'(m * 3 + s)));
            end
        end
        end_test("write_read_all");
    endtask

    task automatic absent_slave_errors();
        start_test("absent_slave");
        write_byte(1, make_addr(3'd3, 8'h00, 4'd5), 8'hEE);
        read_byte(2, make_addr(3'd7, 8'hFF, 4'd5));
        // real slaves must still hold what the model says
        for (int s = 0; s < `NUM_SLAVES; s++) begin
            read_byte(0, make_addr(3'(s), 8'h00, 4'd5));
        end
        end_test("absent_slave");
    endtask

    task automatic three_way_contention();
        start_test("contention");
        // all masters idle so the three commands go out together
        while (busy != '0) @(negedge clk);
        fork
            write_byte(0, make_addr(3'd0, 8'h11, 4'd12), 8'hA1);
            write_byte(1, make_addr(3'd1, 8'h22, 4'd12), 8'hB2);
            write_byte(2, make_addr(3'd2, 8'h33, 4'd12), 8'hC3);
        join
        while (busy != '0) @(negedge clk);
        fork
            read_byte(0, make_addr(3'd2, 8'h33, 4'd12));
            read_byte(1, make_addr(3'd0, 8'h11, 4'd12));
            read_byte(2, make_addr(3'd1, 8'h22, 4'd12));
        join
        end_test("contention");
    endtask

    task automatic random_traffic();
        int                     m;
        logic [2:0]             id;
        logic [7:0]             mid;
        logic [3:0]             idx;
        logic [`DATA_WIDTH-1:0] data;
        logic                   is_write;
        start_test("random_traffic");
        for (int n = 0; n < 40; n++) begin
            m        = int'($unsigned($random(seed)) % `NUM_MASTERS);
            id       = 3'($unsigned($random(seed)) % `NUM_SLAVES);
            mid      = 8'($random(seed));
            idx      = 4'($random(seed));
            data     = 8'($random(seed));
            is_write = 1'($random(seed));
            if (is_write) begin
                write_byte(m, make_addr(id, mid, idx), data);
            end else begin
                read_byte(m, make_addr(id, mid, idx));
            end
        end
        end_test("random_traffic");
    endtask

    task automatic ignore_while_busy();
        int ndone;
        int waited;
        start_test("busy_ignore");
        while (busy[0]) @(negedge clk);
        cmd[0]       = '{op: op_write, addr: make_addr(3'd1, 8'h00, 4'd9), wdata: 8'hC3};
        cmd_valid[0] = 1'b1;
        @(negedge clk);
        cmd_valid[0] = 1'b0;
        repeat (3) @(negedge clk);
        compare("busy[0]", 32'(busy[0]), 32'(1));
        // second command lands while the first is in flight
        cmd[0]       = '{op: op_write, addr: make_addr(3'd2, 8'h00, 4'd9), wdata: 8'h3C};
        cmd_valid[0] = 1'b1;
        @(negedge clk);
        cmd_valid[0] = 1'b0;
        waited = 0;
        while (!done[0] && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done[0]) begin
            $display("no done from master 0 for the first command");
            errors = errors + 1;
        end
        ndone = done[0] ? 1 : 0;
        repeat (60) begin
            @(negedge clk);
            if (done[0]) ndone++;
        end
        compare("done count", 32'(ndone), 32'(1));
        ref_mem[1][9] = 8'hC3;
        read_byte(0, make_addr(3'd1, 8'h00, 4'd9));
        read_byte(0, make_addr(3'd2, 8'h00, 4'd9));
        end_test("busy_ignore");
    endtask

    initial begin
        rst          = 1'b1;
        cmd_valid    = '0;
        cmd          = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        seed         = 15563;
        for (int s = 0; s < `NUM_SLAVES; s++) begin
            for (int i = 0; i < (1 << `MEM_ADDR_WIDTH); i++) begin
                ref_mem[s][i] = '0;
            end
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_reset_state();
        write_read_all();
        absent_slave_errors();
        three_way_contention();
        random_traffic();
        ignore_while_busy();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+design
design/bus_pkg.sv
design/bus_controller.sv
design/bus_master.sv
design/bus_slave.sv
design/bus_top.sv
dv/bus_tb.sv

//--- Makefile
SRCS := $(wildcard design/*.sv design/*.svh dv/*.sv) tb.f

.PHONY: run clean

run: obj_dir/Vbus_tb
	@out="$$(./obj_dir/Vbus_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

obj_dir/Vbus_tb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module bus_tb -f tb.f -o Vbus_tb

clean:
	rm -rf obj_dir
